// File: compile.f
src/axi_xbar_pkg.sv
src/xbar_ar_if.sv
src/xbar_r_if.sv
src/xbar_ingress.sv
src/xbar_egress.sv
src/xbar_r_router.sv
src/axi_xbar.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_axi_xbar.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_axi_xbar -f compile.f -o sim_axi_xbar \
	&& ./obj_dir/sim_axi_xbar | tee /dev/stderr | grep -q "^=== PASS ===$" \
	&& exit 0 || exit 1

// File: tests/tb_axi_xbar.sv
`timescale 1ns/1ns

module tb_axi_xbar
	import axi_xbar_pkg::*;
;

	localparam int TOTAL_READS = 44;

	logic                 clk;
	logic                 reset;
	int                   phase = 0;
	int                   errors;
	int                   pending;
	int                   fails = 0;
	logic [0:1][3:0]      arid_m    = '0;
	logic [0:1][31:0]     araddr_m  = '0;
	logic [0:1][3:0]      arlen_m   = '0;
	logic [0:1][2:0]      arsize_m  = '0;
	logic [0:1][1:0]      arburst_m = '0;
	logic [0:1]           arvalid_m = '0;
	logic [0:1]           rready_m  = '0;
	logic [0:1]           arready_s = '0;
	logic [0:1][4:0]      rid_s     = '0;
	logic [0:1][31:0]     rdata_s   = '0;
	logic [0:1][1:0]      rresp_s   = '0;
	logic [0:1]           rlast_s   = '0;
	logic [0:1]           rvalid_s  = '0;
	wire  [0:1]           arready_m;
	wire  [0:1][3:0]      rid_m;
	wire  [0:1][31:0]     rdata_m;
	wire  [0:1][1:0]      rresp_m;
	wire  [0:1]           rlast_m;
	wire  [0:1]           rvalid_m;
	wire  [0:1][4:0]      arid_s;
	wire  [0:1][31:0]     araddr_s;
	wire  [0:1][3:0]      arlen_s;
	wire  [0:1][2:0]      arsize_s;
	wire  [0:1][1:0]      arburst_s;
	wire  [0:1]           arvalid_s;
	wire  [0:1]           rready_s;

	// Request lists per master and in-order slave model queues
	logic [31:0] rq_addr [2][32];
	logic [3:0]  rq_len  [2][32];
	int          rq_n [2] = '{0, 0};
	int          rq_i [2] = '{0, 0};
	logic [4:0]  sq_id   [2][16];
	logic [31:0] sq_addr [2][16];
	logic [3:0]  sq_len  [2][16];
	int          wp   [2] = '{0, 0};
	int          rp   [2] = '{0, 0};
	int          beat [2] = '{0, 0};
	logic [0:1]  ar_acc = '0;
	logic [0:1]  r_acc  = '0;
	logic [31:0] lfsr   = 32'h8d70;

	tb_clock u_clock (.clk(clk), .reset(reset));
	axi_xbar dut (.aclk(clk), .*);
	tb_checker u_checker (.*);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic next_bit();
		lfsr = lfsr_step(lfsr);
		return lfsr[0];
	endfunction

	// Mode 0 or 1 picks a slave, 2 alternates, 3 mixes slaves and lengths
	task automatic add_reads(input int m, input int n, input int mode, input int len);
		int slave;
		for (int i = 0; i < n; i++) begin
			slave = (mode == 2) ? i % 2 : (mode == 3) ? (i / 3) % 2 : mode;
			rq_addr[m][rq_n[m]] = (32'(slave) << 28) | (32'(m) << 12) | (32'(i) << 6);
			rq_len[m][rq_n[m]]  = 4'((mode == 3) ? (i * 5) % 16 : len);
			rq_n[m]++;
		end
	endtask

	task automatic finish_test(input string name);
		int e0;
		e0 = errors;
		do @(negedge clk);
		while (rq_i[0] < rq_n[0] || rq_i[1] < rq_n[1] || pending != 0);
		if (errors != e0)
			fails++;
		$display("test %0d %s: %s, %0d errors", phase, name, (errors == e0) ? "ok" : "failed",
			errors - e0);
	endtask

	always begin
		@(negedge clk);
		#25;
		for (int m = 0; m < 2; m++)
			ar_acc[m] = arvalid_m[m] && arready_m[m];
		for (int s = 0; s < 2; s++) begin
			if (arvalid_s[s] && arready_s[s]) begin
				sq_id[s][wp[s]]   = arid_s[s];
				sq_addr[s][wp[s]] = araddr_s[s];
				sq_len[s][wp[s]]  = arlen_s[s];
				wp[s] = (wp[s] + 1) % 16;
			end
			r_acc[s] = rvalid_s[s] && rready_s[s];
		end
	end

	always @(negedge clk) begin
		if (!reset) begin
			for (int m = 0; m < 2; m++) begin
				if (ar_acc[m]) begin
					arvalid_m[m] = 1'b0;
					rq_i[m]++;
				end
				if (!arvalid_m[m] && rq_i[m] < rq_n[m]) begin
					arvalid_m[m] = 1'b1;
					arid_m[m]    = 4'(rq_i[m] % 16);
					araddr_m[m]  = rq_addr[m][rq_i[m]];
					arlen_m[m]   = rq_len[m][rq_i[m]];
					arsize_m[m]  = 3'((rq_i[m] + 1) % 3);
					arburst_m[m] = 2'(rq_i[m] % 3);
				end
				rready_m[m] = next_bit();
			end
			for (int s = 0; s < 2; s++) begin
				if (r_acc[s]) begin
					if (beat[s] == int'(sq_len[s][rp[s]])) begin
						beat[s] = 0;
						rp[s]   = (rp[s] + 1) % 16;
					end else begin
						beat[s]++;
					end
				end
				rvalid_s[s]  = (rp[s] != wp[s]);
				rid_s[s]     = sq_id[s][rp[s]];
				rdata_s[s]   = sq_addr[s][rp[s]] + 32'(4 * beat[s]);
				rlast_s[s]   = (beat[s] == int'(sq_len[s][rp[s]]));
				rresp_s[s]   = 2'b00;
				arready_s[s] = next_bit();
			end
		end
	end

	initial begin
		#(TOTAL_READS * 200 * 100);
		$display("timeout: reads did not complete in time");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		@(negedge reset);
		@(negedge clk);
		phase = 1;
		add_reads(0, 4, 2, 1);
		add_reads(1, 4, 2, 2);
		finish_test("routing and id");
		phase = 2;
		add_reads(0, 6, 0, 0);
		add_reads(1, 6, 0, 0);
		finish_test("fairness");
		phase = 3;
		add_reads(0, 8, 2, 3);
		finish_test("no interleave");
		phase = 4;
		add_reads(0, 8, 3, 0);
		add_reads(1, 8, 3, 0);
		finish_test("back-pressure");
		$display("tests: 4, failed: %0d, errors: %0d", fails, errors);
		if (fails == 0 && errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: tests/tb_checker.sv
`timescale 1ns/1ns

module tb_checker
	import axi_xbar_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  int                     phase,
	input  logic [0:1][3:0]        arid_m,
	input  logic [0:1][31:0]       araddr_m,
	input  logic [0:1][3:0]        arlen_m,
	input  logic [0:1][2:0]        arsize_m,
	input  logic [0:1][1:0]        arburst_m,
	input  logic [0:1]             arvalid_m,
	input  logic [0:1]             arready_m,
	input  logic [0:1][3:0]        rid_m,
	input  logic [0:1][31:0]       rdata_m,
	input  logic [0:1][1:0]        rresp_m,
	input  logic [0:1]             rlast_m,
	input  logic [0:1]             rvalid_m,
	input  logic [0:1]             rready_m,
	input  logic [0:1][4:0]        arid_s,
	input  logic [0:1][31:0]       araddr_s,
	input  logic [0:1][3:0]        arlen_s,
	input  logic [0:1][2:0]        arsize_s,
	input  logic [0:1][1:0]        arburst_s,
	input  logic [0:1]             arvalid_s,
	input  logic [0:1]             arready_s,
	output int                     errors,
	output int                     pending
);

	logic [31:0] e_addr [2][16];
	logic [3:0]  e_len  [2][16];
	logic [4:0]  e_ctl  [2][16];
	logic        e_act  [2][16];
	int          cnt    [2];
	int          cur    [2];
	int          prev_top;
	int          ex_slave;
	logic [31:0] ex_data;
	int          m;
	int          id;

	// Expected slave from the address map and expected data for one beat
	function automatic void expect_read(input logic [31:0] addr, input int beat,
			output int slave, output logic [31:0] data);
		slave = -1;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (addr >= SLAVE_BASE[s] && addr <= SLAVE_END[s])
				slave = s;
		end
		data = addr + 32'(4 * beat);
	endfunction

	// Sample late in the cycle ahead of the rising edge that transfers
	always begin
		@(negedge clk);
		#25;
		if (reset) begin
			errors   = 0;
			pending  = 0;
			prev_top = -1;
			cnt      = '{0, 0};
			cur      = '{0, 0};
			for (int i = 0; i < 2; i++)
				for (int j = 0; j < 16; j++)
					e_act[i][j] = 1'b0;
		end else begin
			if (phase != 2)
				prev_top = -1;
			for (int mm = 0; mm < 2; mm++) begin
				if (arvalid_m[mm] && arready_m[mm]) begin
					id = int'(arid_m[mm]);
					if (e_act[mm][id]) begin
						$display("master %0d reused read id %0d while outstanding", mm, id);
						errors++;
					end
					e_addr[mm][id] = araddr_m[mm];
					e_len[mm][id]  = arlen_m[mm];
					e_ctl[mm][id]  = {arsize_m[mm], arburst_m[mm]};
					e_act[mm][id]  = 1'b1;
					pending++;
				end
			end
			for (int s = 0; s < 2; s++) begin
				if (arvalid_s[s] && arready_s[s]) begin
					m  = int'(arid_s[s][4]);
					id = int'(arid_s[s][3:0]);
					expect_read(e_addr[m][id], 0, ex_slave, ex_data);
					if (!e_act[m][id]) begin
						$display("slave %0d got a read address that no master issued", s);
						errors++;
					end else if (ex_slave != s || {araddr_s[s], arlen_s[s], arsize_s[s],
							arburst_s[s]} != {ex_data, e_len[m][id], e_ctl[m][id]}) begin
						$display("ERROR araddr_s/arlen_s/arsize_s/arburst_s[%0d]: %s",
							s, "got and expected follow");
						$display("ERROR got %h expected %h at slave %0d",
							{araddr_s[s], arlen_s[s], arsize_s[s], arburst_s[s]},
							{ex_data, e_len[m][id], e_ctl[m][id]}, ex_slave);
						errors++;
					end
					if (phase == 2 && s == 0) begin
						if (m == prev_top) begin
							$display("slave 0 granted master %0d twice in a row", m);
							errors++;
						end
						prev_top = m;
					end
				end
			end
			for (int mm = 0; mm < 2; mm++) begin
				if (rvalid_m[mm] && rready_m[mm]) begin
					id = int'(rid_m[mm]);
					if (cnt[mm] > 0 && id != cur[mm]) begin
						$display("ERROR rid_m[%0d]: got %h expected %h", mm,
							rid_m[mm], 4'(cur[mm]));
						errors++;
					end else if (!e_act[mm][id]) begin
						$display("master %0d got a beat for id %0d with no read open", mm, id);
						errors++;
					end else begin
						expect_read(e_addr[mm][id], cnt[mm], ex_slave, ex_data);
						if (rdata_m[mm] != ex_data) begin
							$display("ERROR rdata_m[%0d]: got %h expected %h", mm,
								rdata_m[mm], ex_data);
							errors++;
						end
						if (rlast_m[mm] != (cnt[mm] == int'(e_len[mm][id]))
								|| rresp_m[mm] != 2'b00) begin
							$display("ERROR rlast_m/rresp_m[%0d]: got %h expected %h", mm,
								{rlast_m[mm], rresp_m[mm]},
								{cnt[mm] == int'(e_len[mm][id]), 2'b00});
							errors++;
						end
						cur[mm] = id;
						cnt[mm]++;
						if (cnt[mm] > int'(e_len[mm][id])) begin
							cnt[mm]        = 0;
							e_act[mm][id]  = 1'b0;
							pending--;
						end
					end
				end
			end
		end
	end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk   = 1'b0;
		reset = 1'b1;
		forever #50 clk = !clk;
	end

	// Release on a falling edge after two rising edges
	initial begin
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// File: src/axi_xbar.sv
`timescale 1ns/1ns

module axi_xbar
	import axi_xbar_pkg::*;
(
	input  logic                                 aclk,
	input  logic                                 reset,

	// Master side read address
	input  logic [0:NUM_MASTERS-1][ID_WIDTH-1:0]   arid_m,
	input  logic [0:NUM_MASTERS-1][ADDR_WIDTH-1:0] araddr_m,
	input  logic [0:NUM_MASTERS-1][LEN_WIDTH-1:0]  arlen_m,
	input  logic [0:NUM_MASTERS-1][SIZE_WIDTH-1:0] arsize_m,
	input  logic [0:NUM_MASTERS-1][1:0]            arburst_m,
	input  logic [0:NUM_MASTERS-1]                 arvalid_m,
	output wire  [0:NUM_MASTERS-1]                 arready_m,
	// Master side read data
	output wire  [0:NUM_MASTERS-1][ID_WIDTH-1:0]   rid_m,
	output wire  [0:NUM_MASTERS-1][DATA_WIDTH-1:0] rdata_m,
	output wire  [0:NUM_MASTERS-1][1:0]            rresp_m,
	output wire  [0:NUM_MASTERS-1]                 rlast_m,
	output wire  [0:NUM_MASTERS-1]                 rvalid_m,
	input  logic [0:NUM_MASTERS-1]                 rready_m,

	// Slave side read address
	output wire  [0:NUM_SLAVES-1][IDS_WIDTH-1:0]   arid_s,
	output wire  [0:NUM_SLAVES-1][ADDR_WIDTH-1:0]  araddr_s,
	output wire  [0:NUM_SLAVES-1][LEN_WIDTH-1:0]   arlen_s,
	output wire  [0:NUM_SLAVES-1][SIZE_WIDTH-1:0]  arsize_s,
	output wire  [0:NUM_SLAVES-1][1:0]             arburst_s,
	output wire  [0:NUM_SLAVES-1]                  arvalid_s,
	input  logic [0:NUM_SLAVES-1]                  arready_s,
	// Slave side read data
	input  logic [0:NUM_SLAVES-1][IDS_WIDTH-1:0]   rid_s,
	input  logic [0:NUM_SLAVES-1][DATA_WIDTH-1:0]  rdata_s,
	input  logic [0:NUM_SLAVES-1][1:0]             rresp_s,
	input  logic [0:NUM_SLAVES-1]                  rlast_s,
	input  logic [0:NUM_SLAVES-1]                  rvalid_s,
	output wire  [0:NUM_SLAVES-1]                  rready_s
);

	// One link per master/slave pair in each direction
	xbar_ar_if ar_link [NUM_LINKS] ();
	xbar_r_if  r_link  [NUM_LINKS] ();

	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master
		xbar_ingress #(.MASTER_IDX(m)) u_ingress (
			.aclk     (aclk),
			.reset    (reset),
			.arid     (arid_m[m]),
			.araddr   (araddr_m[m]),
			.arlen    (arlen_m[m]),
			.arsize   (arsize_m[m]),
			.arburst  (burst_e'(arburst_m[m])),
			.arvalid  (arvalid_m[m]),
			.arready  (arready_m[m]),
			.to_slave (ar_link)
		);

		xbar_r_router #(.MASTER_IDX(m)) u_router (
			.aclk       (aclk),
			.reset      (reset),
			.from_slave (r_link),
			.rid        (rid_m[m]),
			.rdata      (rdata_m[m]),
			.rresp      (rresp_m[m]),
			.rlast      (rlast_m[m]),
			.rvalid     (rvalid_m[m]),
			.rready     (rready_m[m])
		);
	end

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
		xbar_egress #(.SLAVE_IDX(s)) u_egress (
			.aclk        (aclk),
			.reset       (reset),
			.from_master (ar_link),
			.to_master   (r_link),
			.arid_s      (arid_s[s]),
			.araddr_s    (araddr_s[s]),
			.arlen_s     (arlen_s[s]),
			.arsize_s    (arsize_s[s]),
			.arburst_s   (arburst_s[s]),
			.arvalid_s   (arvalid_s[s]),
			.arready_s   (arready_s[s]),
			.rid_s       (rid_s[s]),
			.rdata_s     (rdata_s[s]),
			.rresp_s     (resp_e'(rresp_s[s])),
			.rlast_s     (rlast_s[s]),
			.rvalid_s    (rvalid_s[s]),
			.rready_s    (rready_s[s])
		);
	end

endmodule

// File: src/xbar_r_router.sv
`timescale 1ns/1ns

module xbar_r_router
	import axi_xbar_pkg::*;
#(
	parameter int MASTER_IDX = 0
)
(
	input  logic                  aclk,
	input  logic                  reset,
	xbar_r_if.dst                 from_slave [NUM_LINKS],
	output logic [ID_WIDTH-1:0]   rid,
	output logic [DATA_WIDTH-1:0] rdata,
	output resp_e                 rresp,
	output logic                  rlast,
	output logic                  rvalid,
	input  logic                  rready
);

	r_state_e              state;
	logic [SIDX_WIDTH-1:0] lock_q;
	logic [SIDX_WIDTH-1:0] rr_ptr;
	logic [SIDX_WIDTH-1:0] pick;
	logic [SIDX_WIDTH-1:0] sel;
	logic [NUM_SLAVES-1:0] s_valid;
	logic [NUM_SLAVES-1:0] s_last;
	logic [ID_WIDTH-1:0]   s_id   [NUM_SLAVES];
	logic [DATA_WIDTH-1:0] s_data [NUM_SLAVES];
	resp_e                 s_resp [NUM_SLAVES];
	logic                  pick_any;
	logic                  beat_done;
	int                    pick_int;

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
		assign s_valid[s] = from_slave[MASTER_IDX*NUM_SLAVES + s].valid;
		assign s_last[s]  = from_slave[MASTER_IDX*NUM_SLAVES + s].last;
		assign s_id[s]    = from_slave[MASTER_IDX*NUM_SLAVES + s].id;
		assign s_data[s]  = from_slave[MASTER_IDX*NUM_SLAVES + s].data;
		assign s_resp[s]  = from_slave[MASTER_IDX*NUM_SLAVES + s].resp;
		assign from_slave[MASTER_IDX*NUM_SLAVES + s].ready = rready && (sel == SIDX_WIDTH'(s));
	end

	// Candidate for the next burst, only used while idle
	assign pick_int = rr_pick(32'(s_valid), int'(rr_ptr), NUM_SLAVES);
	assign pick_any = (pick_int >= 0);
	assign pick     = SIDX_WIDTH'(pick_int);

	assign sel       = (state == R_BURST) ? lock_q : pick;
	assign rvalid    = s_valid[sel];
	assign rid       = s_id[sel];
	assign rdata     = s_data[sel];
	assign rresp     = s_resp[sel];
	assign rlast     = s_last[sel];
	assign beat_done = rvalid && rready && rlast;

	always_ff @(posedge aclk) begin
		if (reset) begin
			state  <= R_IDLE;
			lock_q <= '0;
			rr_ptr <= '0;
		end else begin
			case (state)
				R_IDLE: begin
					if (pick_any) begin
						lock_q <= pick;
						// Lock as soon as a beat shows, unless it finishes at once
						if (beat_done)
							rr_ptr <= SIDX_WIDTH'((pick_int + 1) % NUM_SLAVES);
						else
							state <= R_BURST;
					end
				end
				R_BURST: begin
					if (beat_done) begin
						state  <= R_IDLE;
						rr_ptr <= SIDX_WIDTH'((int'(lock_q) + 1) % NUM_SLAVES);
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	a_lock_hold: assert property (@(posedge aclk) disable iff (reset)
		state == R_BURST && !beat_done |=> state == R_BURST && $stable(lock_q))
		else $error("master %0d read data lock moved inside a burst", MASTER_IDX);

endmodule

// File: src/xbar_egress.sv
`timescale 1ns/1ns

module xbar_egress
	import axi_xbar_pkg::*;
#(
	parameter int SLAVE_IDX = 0
)
(
	input  logic                  aclk,
	input  logic                  reset,
	xbar_ar_if.dst                from_master [NUM_LINKS],
	xbar_r_if.src                 to_master [NUM_LINKS],
	output logic [IDS_WIDTH-1:0]  arid_s,
	output logic [ADDR_WIDTH-1:0] araddr_s,
	output logic [LEN_WIDTH-1:0]  arlen_s,
	output logic [SIZE_WIDTH-1:0] arsize_s,
	output burst_e                arburst_s,
	output logic                  arvalid_s,
	input  logic                  arready_s,
	input  logic [IDS_WIDTH-1:0]  rid_s,
	input  logic [DATA_WIDTH-1:0] rdata_s,
	input  resp_e                 rresp_s,
	input  logic                  rlast_s,
	input  logic                  rvalid_s,
	output logic                  rready_s
);

	logic [NUM_MASTERS-1:0] req;
	logic [ID_WIDTH-1:0]    req_id    [NUM_MASTERS];
	logic [ADDR_WIDTH-1:0]  req_addr  [NUM_MASTERS];
	logic [LEN_WIDTH-1:0]   req_len   [NUM_MASTERS];
	logic [SIZE_WIDTH-1:0]  req_size  [NUM_MASTERS];
	burst_e                 req_burst [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] r_ready;
	logic [MIDX_WIDTH-1:0]  rr_ptr;
	logic [MIDX_WIDTH-1:0]  win_idx;
	logic [MIDX_WIDTH-1:0]  r_dest;
	logic                   win_any;
	logic                   out_free;
	logic                   grant;
	int                     win;

	// Returning beats go to the master named by the RID top bit
	assign r_dest   = rid_s[IDS_WIDTH-1 -: MIDX_WIDTH];
	assign rready_s = r_ready[r_dest];

	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master
		assign req[m]       = from_master[m*NUM_SLAVES + SLAVE_IDX].valid;
		assign req_id[m]    = from_master[m*NUM_SLAVES + SLAVE_IDX].id;
		assign req_addr[m]  = from_master[m*NUM_SLAVES + SLAVE_IDX].addr;
		assign req_len[m]   = from_master[m*NUM_SLAVES + SLAVE_IDX].len;
		assign req_size[m]  = from_master[m*NUM_SLAVES + SLAVE_IDX].size;
		assign req_burst[m] = from_master[m*NUM_SLAVES + SLAVE_IDX].burst;
		assign from_master[m*NUM_SLAVES + SLAVE_IDX].ready = grant && (win_idx == MIDX_WIDTH'(m));

		assign to_master[m*NUM_SLAVES + SLAVE_IDX].valid = rvalid_s && (r_dest == MIDX_WIDTH'(m));
		assign to_master[m*NUM_SLAVES + SLAVE_IDX].id    = rid_s[ID_WIDTH-1:0];
		assign to_master[m*NUM_SLAVES + SLAVE_IDX].data  = rdata_s;
		assign to_master[m*NUM_SLAVES + SLAVE_IDX].resp  = rresp_s;
		assign to_master[m*NUM_SLAVES + SLAVE_IDX].last  = rlast_s;
		assign r_ready[m] = to_master[m*NUM_SLAVES + SLAVE_IDX].ready;
	end

	// Output register frees on the slave handshake
	assign out_free = !arvalid_s || arready_s;
	assign win      = rr_pick(32'(req), int'(rr_ptr), NUM_MASTERS);
	assign win_any  = (win >= 0);
	assign win_idx  = MIDX_WIDTH'(win);
	assign grant    = out_free && win_any;

	always_ff @(posedge aclk) begin
		if (reset) begin
			arvalid_s <= 1'b0;
			rr_ptr    <= '0;
		end else if (grant) begin
			arvalid_s <= 1'b1;
			// Priority moves past the winner
			rr_ptr    <= MIDX_WIDTH'((win + 1) % NUM_MASTERS);
		end else if (arready_s) begin
			arvalid_s <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (grant) begin
			arid_s    <= {win_idx, req_id[win_idx]};
			araddr_s  <= req_addr[win_idx];
			arlen_s   <= req_len[win_idx];
			arsize_s  <= req_size[win_idx];
			arburst_s <= req_burst[win_idx];
		end
	end

	a_ar_hold: assert property (@(posedge aclk) disable iff (reset)
		arvalid_s && !arready_s |=> arvalid_s && $stable(arid_s) && $stable(araddr_s)
			&& $stable(arlen_s) && $stable(arsize_s) && $stable(arburst_s))
		else $error("slave %0d AR request changed before arready", SLAVE_IDX);

endmodule

// File: src/xbar_ingress.sv
`timescale 1ns/1ns

module xbar_ingress
	import axi_xbar_pkg::*;
#(
	parameter int MASTER_IDX = 0
)
(
	input  logic                  aclk,
	input  logic                  reset,
	input  logic [ID_WIDTH-1:0]   arid,
	input  logic [ADDR_WIDTH-1:0] araddr,
	input  logic [LEN_WIDTH-1:0]  arlen,
	input  logic [SIZE_WIDTH-1:0] arsize,
	input  burst_e                arburst,
	input  logic                  arvalid,
	output logic                  arready,
	xbar_ar_if.src                to_slave [NUM_LINKS]
);

	logic                  full;
	logic [NUM_SLAVES-1:0] hit;
	logic [NUM_SLAVES-1:0] hit_q;
	logic [NUM_SLAVES-1:0] taken;
	logic [ID_WIDTH-1:0]   id_q;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [LEN_WIDTH-1:0]  len_q;
	logic [SIZE_WIDTH-1:0] size_q;
	burst_e                burst_q;

	// Window compare against the fixed map
	always_comb begin
		for (int s = 0; s < NUM_SLAVES; s++) begin
			hit[s] = (araddr >= SLAVE_BASE[s]) && (araddr <= SLAVE_END[s]);
		end
	end

	assign arready = !full;

	always_ff @(posedge aclk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (arvalid && arready) begin
			full <= 1'b1;
		end else if (|taken) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (arvalid && arready) begin
			hit_q   <= hit;
			id_q    <= arid;
			addr_q  <= araddr;
			len_q   <= arlen;
			size_q  <= arsize;
			burst_q <= arburst;
		end
	end

	// Only the decoded slave sees valid
	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_link
		assign to_slave[MASTER_IDX*NUM_SLAVES + s].valid = full && hit_q[s];
		assign to_slave[MASTER_IDX*NUM_SLAVES + s].id    = id_q;
		assign to_slave[MASTER_IDX*NUM_SLAVES + s].addr  = addr_q;
		assign to_slave[MASTER_IDX*NUM_SLAVES + s].len   = len_q;
		assign to_slave[MASTER_IDX*NUM_SLAVES + s].size  = size_q;
		assign to_slave[MASTER_IDX*NUM_SLAVES + s].burst = burst_q;
		assign taken[s] = full && hit_q[s] && to_slave[MASTER_IDX*NUM_SLAVES + s].ready;
	end

	// An accepted address must land in exactly one window
	a_decode_hit: assert property (@(posedge aclk) disable iff (reset)
		arvalid && arready |=> $onehot(hit_q))
		else $error("master %0d read address %h outside the address map", MASTER_IDX, addr_q);

endmodule

// File: src/xbar_r_if.sv
`timescale 1ns/1ns

interface xbar_r_if import axi_xbar_pkg::*; ();

	// Master-side ID with the index bit already stripped
	logic [ID_WIDTH-1:0]   id;
	logic [DATA_WIDTH-1:0] data;
	resp_e                 resp;
	logic                  last;
	logic                  valid;
	logic                  ready;

	modport src (
		output id, data, resp, last, valid,
		input  ready
	);

	modport dst (
		input  id, data, resp, last, valid,
		output ready
	);

endinterface

// File: src/xbar_ar_if.sv
`timescale 1ns/1ns

interface xbar_ar_if import axi_xbar_pkg::*; ();

	logic [ID_WIDTH-1:0]   id;
	logic [ADDR_WIDTH-1:0] addr;
	logic [LEN_WIDTH-1:0]  len;
	logic [SIZE_WIDTH-1:0] size;
	burst_e                burst;
	logic                  valid;
	logic                  ready;

	// Ingress side
	modport src (
		output id, addr, len, size, burst, valid,
		input  ready
	);

	// Slave port arbiter side
	modport dst (
		input  id, addr, len, size, burst, valid,
		output ready
	);

endinterface

// File: src/axi_xbar_pkg.sv
package axi_xbar_pkg;

	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES  = 2;
	// Master/slave links are numbered master * NUM_SLAVES + slave
	localparam int NUM_LINKS   = NUM_MASTERS * NUM_SLAVES;
	localparam int MIDX_WIDTH  = $clog2(NUM_MASTERS);
	localparam int SIDX_WIDTH  = $clog2(NUM_SLAVES);

	localparam int ID_WIDTH   = 4;
	// Slave side carries the master index as the top ID bit
	localparam int IDS_WIDTH  = ID_WIDTH + MIDX_WIDTH;
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int LEN_WIDTH  = 4;
	localparam int SIZE_WIDTH = 3;

	// Address windows with inclusive bounds
	localparam logic [0:NUM_SLAVES-1][ADDR_WIDTH-1:0] SLAVE_BASE = {32'h0000_0000, 32'h1000_0000};
	localparam logic [0:NUM_SLAVES-1][ADDR_WIDTH-1:0] SLAVE_END  = {32'h0fff_ffff, 32'h1fff_ffff};

	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	typedef enum logic {
		R_IDLE  = 1'b0,
		R_BURST = 1'b1
	} r_state_e;

	// First requester at or after ptr or -1 when nobody requests
	function automatic int rr_pick(input logic [31:0] req, input int ptr, input int n);
		int idx;
		rr_pick = -1;
		for (int k = n - 1; k >= 0; k--) begin
			idx = (ptr + k) % n;
			if (req[idx])
				rr_pick = idx;
		end
	endfunction

endpackage
